//--- hdl/spi_mem_pkg.sv
package spi_mem_pkg;

	// memory geometry
	localparam int addr_width = 8;
	localparam int data_width = 8;
	localparam int mem_depth = 256;

	// idle counter in the spi front end
	// fires after 15 clk cycles without a falling spi_clk edge
	localparam int timeout_width = 4;

	// command byte, the first byte of every transaction
	typedef enum logic [7:0]
	{
		op_write = 8'h02,
		op_read = 8'h03
	} spi_opcode_t;

	// command engine sequence
	// cmd -> addr -> write or read, ignore swallows the rest of a transaction
	typedef enum logic [2:0]
	{
		st_cmd,
		st_addr,
		st_write,
		st_read,
		st_ignore
	} engine_state_t;

endpackage

//--- hdl/mem_bus_if.sv
interface mem_bus_if;

	// level request, held with stable we/addr/wdata until gnt
	logic req;
	logic we;
	logic [spi_mem_pkg::addr_width-1:0] addr;
	logic [spi_mem_pkg::data_width-1:0] wdata;
	// one-cycle acknowledge, read data follows one cycle later
	logic gnt;
	logic [spi_mem_pkg::data_width-1:0] rdata;

	modport requester (output req, output we, output addr, output wdata,
		input gnt, input rdata);

	modport arbiter (input req, input we, input addr, input wdata,
		output gnt, output rdata);

endinterface

//--- hdl/spi_device.sv
module spi_device (
	input  logic clk,
	input  logic reset,
	input  logic spi_clk,
	input  logic spi_cs,
	input  logic spi_mosi,
	output logic spi_miso,
	output logic rx_cmd,
	output logic rx_strobe,
	output logic [spi_mem_pkg::data_width-1:0] rx_data,
	input  logic [spi_mem_pkg::data_width-1:0] tx_data,
	input  logic tx_strobe,
	output logic spi_timeout,
	output logic cs_active
);

	// two sync stages per pin, spi_clk has one extra stage for edge detect
	logic [2:0] clk_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic clk_rising;
	logic clk_falling;
	logic [spi_mem_pkg::timeout_width-1:0] idle_count;
	logic [2:0] bit_count;
	logic cmd_started;
	logic [spi_mem_pkg::data_width-1:0] mosi_reg;
	// top bit drives the pin, the low byte is the reload target
	logic [spi_mem_pkg::data_width:0] miso_reg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			clk_sync <= '0;
			cs_sync <= '1;
			mosi_sync <= '0;
		end
		else
		begin
			clk_sync <= {clk_sync[1:0], spi_clk};
			cs_sync <= {cs_sync[0], spi_cs};
			mosi_sync <= {mosi_sync[0], spi_mosi};
		end
	end

	assign clk_rising = clk_sync[1] && !clk_sync[2];
	assign clk_falling = !clk_sync[1] && clk_sync[2];
	assign cs_active = !cs_sync[1];

	// idle clock watchdog, reloaded by every falling edge
	// held at full count while chip select is high
	always_ff @(posedge clk)
	begin
		if (reset || cs_sync[1] || clk_falling)
			idle_count <= '1;
		else if (idle_count != '0)
			idle_count <= idle_count - 1'b1;
	end

	assign spi_timeout = (idle_count == '0);

	// byte is handed out unlatched, in the same cycle as the eighth rising edge
	assign rx_data = {mosi_reg[spi_mem_pkg::data_width-2:0], mosi_sync[1]};
	assign rx_strobe = clk_rising && cs_active && (bit_count == 3'd7);
	assign rx_cmd = rx_strobe && !cmd_started;

	assign spi_miso = miso_reg[spi_mem_pkg::data_width];

	always_ff @(posedge clk)
	begin
		if (reset || cs_sync[1])
		begin
			// new transaction starts from bit zero with miso idling high
			bit_count <= '0;
			cmd_started <= 1'b0;
			miso_reg <= '1;
		end
		else if (clk_rising)
		begin
			bit_count <= bit_count + 1'b1;
			if (bit_count == 3'd7)
				cmd_started <= 1'b1;
		end
		else if (tx_strobe)
		begin
			// reload lands on the pin at the next falling edge
			miso_reg[spi_mem_pkg::data_width-1:0] <= tx_data;
		end
		else if (clk_falling)
		begin
			// shift out, the last bit stays put
			miso_reg <= {miso_reg[spi_mem_pkg::data_width-1:0], miso_reg[0]};
		end
	end

	// receive shifter
	always_ff @(posedge clk)
	begin
		if (clk_rising)
			mosi_reg <= rx_data;
	end

	// a reload on a rising edge cycle would be lost
	a_tx_not_on_rise: assert property (@(posedge clk) disable iff (reset)
		!(tx_strobe && clk_rising));

endmodule

//--- hdl/spi_cmd_engine.sv
module spi_cmd_engine (
	input  logic clk,
	input  logic reset,
	input  logic rx_cmd,
	input  logic rx_strobe,
	input  logic [spi_mem_pkg::data_width-1:0] rx_data,
	input  logic spi_timeout,
	input  logic cs_active,
	output logic [spi_mem_pkg::data_width-1:0] tx_data,
	output logic tx_strobe,
	mem_bus_if.requester bus
);

	spi_mem_pkg::engine_state_t state;
	spi_mem_pkg::spi_opcode_t cmd_op;
	// next address of the burst
	logic [spi_mem_pkg::addr_width-1:0] addr_cnt;
	// access started by the current byte
	logic issue;
	logic issue_we;
	logic [spi_mem_pkg::addr_width-1:0] issue_addr;
	// access still waiting for its grant
	logic pend;
	logic pend_we;
	logic [spi_mem_pkg::addr_width-1:0] pend_addr;
	logic [spi_mem_pkg::data_width-1:0] pend_wdata;
	// read granted last cycle, data is on rdata now
	logic rd_wait;

	always_comb
	begin
		issue = 1'b0;
		issue_we = 1'b0;
		issue_addr = addr_cnt;
		if (rx_strobe && !spi_timeout)
		begin
			case (state)
				spi_mem_pkg::st_addr:
				begin
					// a read fetches straight from the address byte
					issue = (cmd_op == spi_mem_pkg::op_read);
					issue_addr = rx_data;
				end
				spi_mem_pkg::st_write:
				begin
					issue = 1'b1;
					issue_we = 1'b1;
				end
				spi_mem_pkg::st_read:
					issue = 1'b1;
				default:
					issue = 1'b0;
			endcase
		end
	end

	// request goes out in the strobe cycle, pending copy covers a lost grant
	assign bus.req = pend || issue;
	assign bus.we = pend ? pend_we : issue_we;
	assign bus.addr = pend ? pend_addr : issue_addr;
	assign bus.wdata = pend ? pend_wdata : rx_data;

	// returned byte reloads the miso shifter
	assign tx_data = bus.rdata;
	assign tx_strobe = rd_wait;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= spi_mem_pkg::st_cmd;
			pend <= 1'b0;
			rd_wait <= 1'b0;
		end
		else
		begin
			rd_wait <= bus.req && bus.gnt && !bus.we;
			if (pend && bus.gnt)
				pend <= 1'b0;
			else if (issue && !bus.gnt)
				pend <= 1'b1;

			if (!cs_active)
				state <= spi_mem_pkg::st_cmd;
			else if (spi_timeout && state inside {spi_mem_pkg::st_addr,
				spi_mem_pkg::st_write, spi_mem_pkg::st_read})
				state <= spi_mem_pkg::st_ignore;
			else
			begin
				case (state)
					spi_mem_pkg::st_cmd:
						if (rx_cmd)
							state <= (rx_data == spi_mem_pkg::op_read ||
								rx_data == spi_mem_pkg::op_write) ?
								spi_mem_pkg::st_addr : spi_mem_pkg::st_ignore;
					spi_mem_pkg::st_addr:
						if (rx_strobe)
							state <= (cmd_op == spi_mem_pkg::op_read) ?
								spi_mem_pkg::st_read : spi_mem_pkg::st_write;
					default:
						state <= state;
				endcase
			end
		end
	end

	// opcode, address counter and pending payload
	always_ff @(posedge clk)
	begin
		if (state == spi_mem_pkg::st_cmd && rx_cmd)
			cmd_op <= spi_mem_pkg::spi_opcode_t'(rx_data);
		if (issue)
			addr_cnt <= issue_addr + 1'b1;
		else if (state == spi_mem_pkg::st_addr && rx_strobe)
			addr_cnt <= rx_data;
		if (issue)
		begin
			pend_we <= issue_we;
			pend_addr <= issue_addr;
			pend_wdata <= rx_data;
		end
	end

	// serial byte rate leaves room for every access to be granted first
	a_no_rx_while_pend: assert property (@(posedge clk) disable iff (reset)
		rx_strobe |-> !pend);

endmodule

//--- hdl/mem_arbiter.sv
module mem_arbiter (
	input  logic clk,
	input  logic reset,
	mem_bus_if.arbiter spi_side,
	mem_bus_if.arbiter host_side,
	output logic mem_en,
	output logic mem_we,
	output logic [spi_mem_pkg::addr_width-1:0] mem_addr,
	output logic [spi_mem_pkg::data_width-1:0] mem_wdata,
	input  logic [spi_mem_pkg::data_width-1:0] mem_rdata
);

	// who owned the port last cycle
	logic spi_took;
	logic host_took;

	// spi always wins and the host only gets idle cycles
	assign spi_side.gnt = spi_side.req;
	assign host_side.gnt = host_side.req && !spi_side.req;

	// winner onto the memory port
	assign mem_en = spi_side.req || host_side.req;
	assign mem_we = spi_side.req ? spi_side.we : host_side.we;
	assign mem_addr = spi_side.req ? spi_side.addr : host_side.addr;
	assign mem_wdata = spi_side.req ? spi_side.wdata : host_side.wdata;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			spi_took <= 1'b0;
			host_took <= 1'b0;
		end
		else
		begin
			spi_took <= spi_side.gnt;
			host_took <= host_side.gnt;
		end
	end

	// registered read data back to the side that issued it
	assign spi_side.rdata = spi_took ? mem_rdata : '0;
	assign host_side.rdata = host_took ? mem_rdata : '0;

	// a waiting host request keeps its fields until it is granted
	a_host_hold: assert property (@(posedge clk) disable iff (reset)
		host_side.req && !host_side.gnt |=> host_side.req &&
		$stable({host_side.we, host_side.addr, host_side.wdata}));

endmodule

//--- hdl/mem_bank.sv
module mem_bank (
	input  logic clk,
	input  logic mem_en,
	input  logic mem_we,
	input  logic [spi_mem_pkg::addr_width-1:0] mem_addr,
	input  logic [spi_mem_pkg::data_width-1:0] mem_wdata,
	output logic [spi_mem_pkg::data_width-1:0] mem_rdata
);

	// byte array, contents survive reset
	logic [spi_mem_pkg::data_width-1:0] mem [spi_mem_pkg::mem_depth];

	always_ff @(posedge clk)
	begin
		if (mem_en)
		begin
			if (mem_we)
				mem[mem_addr] <= mem_wdata;
			// registered read, old data on a write cycle
			mem_rdata <= mem[mem_addr];
		end
	end

endmodule

//--- hdl/spi_mem_top.sv
module spi_mem_top (
	input  logic clk,
	input  logic reset,
	input  logic spi_clk,
	input  logic spi_cs,
	input  logic spi_mosi,
	output logic spi_miso,
	input  logic host_req,
	input  logic host_we,
	input  logic [spi_mem_pkg::addr_width-1:0] host_addr,
	input  logic [spi_mem_pkg::data_width-1:0] host_wdata,
	output logic host_gnt,
	output logic [spi_mem_pkg::data_width-1:0] host_rdata
);

	// device to engine strobes
	logic rx_cmd;
	logic rx_strobe;
	logic [spi_mem_pkg::data_width-1:0] rx_data;
	logic [spi_mem_pkg::data_width-1:0] tx_data;
	logic tx_strobe;
	logic spi_timeout;
	logic cs_active;
	// arbiter to memory
	logic mem_en;
	logic mem_we;
	logic [spi_mem_pkg::addr_width-1:0] mem_addr;
	logic [spi_mem_pkg::data_width-1:0] mem_wdata;
	logic [spi_mem_pkg::data_width-1:0] mem_rdata;

	mem_bus_if spi_bus ();
	mem_bus_if host_bus ();

	// host pins straight onto the host requester
	assign host_bus.req = host_req;
	assign host_bus.we = host_we;
	assign host_bus.addr = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_gnt = host_bus.gnt;
	assign host_rdata = host_bus.rdata;

	spi_device spi_device0 (.clk(clk), .reset(reset), .spi_clk(spi_clk), .spi_cs(spi_cs),
		.spi_mosi(spi_mosi), .spi_miso(spi_miso), .rx_cmd(rx_cmd), .rx_strobe(rx_strobe),
		.rx_data(rx_data), .tx_data(tx_data), .tx_strobe(tx_strobe),
		.spi_timeout(spi_timeout), .cs_active(cs_active));

	spi_cmd_engine spi_cmd_engine0 (.clk(clk), .reset(reset), .rx_cmd(rx_cmd),
		.rx_strobe(rx_strobe), .rx_data(rx_data), .spi_timeout(spi_timeout),
		.cs_active(cs_active), .tx_data(tx_data), .tx_strobe(tx_strobe), .bus(spi_bus));

	mem_arbiter mem_arbiter0 (.clk(clk), .reset(reset), .spi_side(spi_bus),
		.host_side(host_bus), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata));

	mem_bank mem_bank0 (.clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata));

endmodule

//--- verif/tb_spi_mem.sv
module tb_spi_mem;

	timeunit 1ns;
	timeprecision 1ps;

	// kinds of table steps
	localparam logic [2:0] do_host_wr = 3'd0;
	localparam logic [2:0] do_host_rd = 3'd1;
	localparam logic [2:0] do_spi_wr = 3'd2;
	localparam logic [2:0] do_spi_rd = 3'd3;
	localparam logic [2:0] do_spi_odd = 3'd4;
	localparam logic [2:0] do_mixed = 3'd5;
	localparam logic [2:0] no_stall = 3'd7;
	// command bytes on the wire
	localparam logic [7:0] cmd_write = 8'h02;
	localparam logic [7:0] cmd_read = 8'h03;
	localparam logic [7:0] cmd_unknown = 8'ha5;
	// spi clock half period and mid-transfer stall in clk cycles
	localparam int spi_half = 6;
	localparam int stall_cycles = 30;
	localparam int n_steps = 15;

	// data byte 0 of a table row sits in the top byte
	// stall_at is the number of data bytes sent before the clock stalls
	typedef struct packed
	{
		logic [2:0] op;
		logic [7:0] addr;
		logic [2:0] len;
		logic [31:0] data;
		logic [2:0] stall_at;
	} step_t;

	step_t steps [n_steps] = '{
		'{do_host_wr, 8'h10, 3'd1, 32'h5a00_0000, no_stall},
		'{do_host_rd, 8'h10, 3'd1, 32'h0, no_stall},
		'{do_spi_wr, 8'h20, 3'd4, 32'h1122_3344, no_stall},
		'{do_host_rd, 8'h20, 3'd4, 32'h0, no_stall},
		// burst wraps from ff to 00
		'{do_spi_wr, 8'hfe, 3'd4, 32'ha1b2_c3d4, no_stall},
		'{do_host_rd, 8'hfe, 3'd4, 32'h0, no_stall},
		'{do_spi_rd, 8'h1e, 3'd4, 32'h0, no_stall},
		'{do_spi_rd, 8'hfd, 3'd4, 32'h0, no_stall},
		'{do_spi_odd, 8'h40, 3'd3, 32'h9988_7700, no_stall},
		'{do_spi_rd, 8'h40, 3'd3, 32'h0, no_stall},
		// host traffic at addr ^ 80 while spi writes
		'{do_mixed, 8'h60, 3'd4, 32'hc0ff_ee01, no_stall},
		'{do_host_rd, 8'h60, 3'd4, 32'h0, no_stall},
		'{do_spi_wr, 8'h70, 3'd4, 32'he1e2_e3e4, 3'd2},
		'{do_host_rd, 8'h70, 3'd4, 32'h0, no_stall},
		'{do_spi_rd, 8'h70, 3'd4, 32'h0, no_stall}
	};

	logic clk = 1'b0;
	logic reset;
	logic spi_clk;
	logic spi_cs;
	logic spi_mosi;
	logic spi_miso;
	logic host_req;
	logic host_we;
	logic [7:0] host_addr;
	logic [7:0] host_wdata;
	logic host_gnt;
	logic [7:0] host_rdata;

	// expected memory contents
	logic [7:0] ref_mem [spi_mem_pkg::mem_depth];
	logic [7:0] spi_tx [$];
	logic [7:0] spi_rx [$];
	logic spi_done;
	int seed = 32'ha2fb;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int limit = 0;

	spi_mem_top dut0 (.clk(clk), .reset(reset), .spi_clk(spi_clk), .spi_cs(spi_cs),
		.spi_mosi(spi_mosi), .spi_miso(spi_miso), .host_req(host_req), .host_we(host_we),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_gnt(host_gnt),
		.host_rdata(host_rdata));

	always #5 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout: the run did not finish within %0d clk cycles", limit);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// the host must never share a grant cycle with spi
	// and never see a grant without its request
	always @(negedge clk)
	begin
		#1;
		if (host_gnt && dut0.spi_bus.gnt)
		begin
			errors++;
			$display("error at %0t: host and SPI were granted in the same cycle", $time);
		end
		if (!host_req)
			check("host_gnt", {7'd0, host_gnt}, 8'h00);
	end

	task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	function automatic logic [7:0] data_byte(input step_t st, input int k);
		return st.data[31 - 8 * k -: 8];
	endfunction

	// 250 cycles per step plus the preload and the serial bit time of every spi step
	function automatic int run_budget();
		int total;
		total = spi_mem_pkg::mem_depth * 4;
		foreach (steps[i])
		begin
			total += 250;
			if (steps[i].op != do_host_wr && steps[i].op != do_host_rd)
				total += (int'(steps[i].len) + 2) * 16 * spi_half + stall_cycles + 4 * spi_half;
		end
		return total;
	endfunction

	// grant is combinational, so look just after the falling edge
	// spi is idle whenever this is called and the grant must come at once
	task automatic wait_grant();
		int waited;
		waited = 0;
		#1;
		while (host_gnt !== 1'b1)
		begin
			waited++;
			@(negedge clk);
			#1;
		end
		check("host_gnt_wait", 8'(waited), 8'h00);
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge clk);
		host_req = 1'b1;
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		wait_grant();
		@(negedge clk);
		host_req = 1'b0;
		host_we = 1'b0;
	endtask

	// read data shows up one cycle after the grant
	task automatic host_read(input logic [7:0] addr, output logic [7:0] data);
		@(negedge clk);
		host_req = 1'b1;
		host_we = 1'b0;
		host_addr = addr;
		wait_grant();
		@(negedge clk);
		data = host_rdata;
		host_req = 1'b0;
	endtask

	// back-to-back reads with req held until spi finishes
	// each spi write byte should cost the host exactly one cycle
	task automatic host_read_hold(input logic [7:0] addr, input int spi_grants);
		logic granted;
		int blocked;
		blocked = 0;
		@(negedge clk);
		host_req = 1'b1;
		host_we = 1'b0;
		host_addr = addr;
		do
		begin
			#1;
			granted = host_gnt;
			if (!granted)
				blocked++;
			@(negedge clk);
			if (granted)
				check("host_rdata", host_rdata, ref_mem[addr]);
		end
		while (!spi_done);
		host_req = 1'b0;
		check("host_wait_cycles", 8'(blocked), 8'(spi_grants));
	endtask

	// mode 0 master drives mosi while spi_clk is low and takes miso on the rising edge
	task automatic spi_transfer(input int stall_after);
		logic [7:0] tx_byte;
		logic [7:0] rx_byte;
		spi_rx.delete();
		@(negedge clk);
		spi_cs = 1'b0;
		wait_cycles(spi_half);
		foreach (spi_tx[i])
		begin
			tx_byte = spi_tx[i];
			rx_byte = 8'h00;
			for (int b = 7; b >= 0; b--)
			begin
				spi_mosi = tx_byte[b];
				wait_cycles(spi_half);
				spi_clk = 1'b1;
				rx_byte = {rx_byte[6:0], spi_miso};
				wait_cycles(spi_half);
				spi_clk = 1'b0;
			end
			spi_rx.push_back(rx_byte);
			// clock held low long enough for the idle timeout
			if (i == stall_after)
				wait_cycles(stall_cycles);
		end
		wait_cycles(spi_half);
		spi_cs = 1'b1;
		wait_cycles(spi_half);
	endtask

	// opcode, address, then data bytes or zero fill for reads
	task automatic load_spi_tx(input logic [7:0] op, input step_t st, input logic with_data);
		spi_tx.delete();
		spi_tx.push_back(op);
		spi_tx.push_back(st.addr);
		for (int k = 0; k < int'(st.len); k++)
			spi_tx.push_back(with_data ? data_byte(st, k) : 8'h00);
	endtask

	task automatic spi_write(input step_t st);
		int stall_index;
		load_spi_tx(cmd_write, st, 1'b1);
		stall_index = (st.stall_at == no_stall) ? -1 : int'(st.stall_at) + 1;
		spi_transfer(stall_index);
		// bytes after a stall are dropped by the timeout
		for (int k = 0; k < int'(st.len); k++)
			if (st.stall_at == no_stall || k < int'(st.stall_at))
				ref_mem[st.addr + 8'(k)] = data_byte(st, k);
	endtask

	task automatic apply_step(input step_t st);
		logic [7:0] a;
		logic [7:0] got;
		case (st.op)
			do_host_wr:
				for (int k = 0; k < int'(st.len); k++)
				begin
					a = st.addr + 8'(k);
					ref_mem[a] = data_byte(st, k);
					host_write(a, ref_mem[a]);
				end
			do_host_rd:
				for (int k = 0; k < int'(st.len); k++)
				begin
					a = st.addr + 8'(k);
					host_read(a, got);
					check($sformatf("host_rdata[%02h]", a), got, ref_mem[a]);
				end
			do_spi_wr:
				spi_write(st);
			do_spi_rd:
			begin
				load_spi_tx(cmd_read, st, 1'b0);
				spi_transfer(-1);
				// data starts with the byte after the address
				for (int k = 0; k < int'(st.len); k++)
				begin
					a = st.addr + 8'(k);
					check($sformatf("spi_miso[%02h]", a), spi_rx[k + 2], ref_mem[a]);
				end
			end
			do_spi_odd:
			begin
				// an unknown opcode leaves memory as it was
				load_spi_tx(cmd_unknown, st, 1'b1);
				spi_transfer(-1);
			end
			do_mixed:
			begin
				a = st.addr ^ 8'h80;
				spi_done = 1'b0;
				fork
					begin
						spi_write(st);
						spi_done = 1'b1;
					end
					begin
						ref_mem[a] = ~data_byte(st, 0);
						host_write(a, ref_mem[a]);
						host_read_hold(a, int'(st.len));
					end
				join
			end
			default:
			begin
				errors++;
				$display("error: table step with unknown kind %0d", st.op);
			end
		endcase
	endtask

	initial
	begin
		int rnd;
		limit = run_budget();
		reset = 1'b1;
		spi_clk = 1'b0;
		spi_cs = 1'b1;
		spi_mosi = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = 8'h00;
		host_wdata = 8'h00;
		spi_done = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// whole memory filled with random bytes through the host port
		for (int i = 0; i < spi_mem_pkg::mem_depth; i++)
		begin
			rnd = $random(seed);
			ref_mem[i] = rnd[7:0];
			host_write(8'(i), rnd[7:0]);
		end

		foreach (steps[i])
			apply_step(steps[i]);
		wait_cycles(4);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- all.f
hdl/spi_mem_pkg.sv
hdl/mem_bus_if.sv
hdl/spi_device.sv
hdl/spi_cmd_engine.sv
hdl/mem_arbiter.sv
hdl/mem_bank.sv
hdl/spi_mem_top.sv
verif/tb_spi_mem.sv

//--- Makefile
# Verilator build and run of the SPI memory testbench
# any variable can be overridden, for example: make run LOG=other.log

VERILATOR ?= verilator
TOP ?= tb_spi_mem
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= ALL TESTS PASSED

SIM_EXE = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_EXE) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
